/* common/mouse_params.svh */
/*
  build-time constants for the mouse core
  the register window must be aligned to its own size
  the window width covers 32 words, so it is always 7 address bits
  reset address must be word aligned
*/
`ifndef MOUSE_PARAMS_SVH
`define MOUSE_PARAMS_SVH

// first fetch after reset
`define MOUSE_RST_ADR 32'h0000_0000

// base of the 128 byte register window
`define MOUSE_GPR_ADR 32'h8000_0000

// low address bits inside the window
`define MOUSE_GPR_AW 7

`endif

/* common/mouse_isa_pkg.sv */
/*
  RV32I subset encodings used by the mouse core
  only the opcodes and funct3 codes the core executes are named
  the instruction union overlays all six formats on one word
*/
`default_nettype none

package mouse_isa_pkg;

  //////////////////////////////////////////////////
  // major opcodes, instruction bits 6:2
  typedef enum logic [4:0] {
    LOAD   = 5'b00_000,
    OP_IMM = 5'b00_100,
    STORE  = 5'b01_000,
    OP     = 5'b01_100,
    LUI    = 5'b01_101,
    BRANCH = 5'b11_000,
    JALR   = 5'b11_001,
    JAL    = 5'b11_011
  } opc_t;

  // alu funct3 (OP and OP-IMM)
  typedef enum logic [2:0] {
    ADD  = 3'b000,  // SUB when funct7[5] in OP
    SLT  = 3'b010,
    SLTU = 3'b011,
    XOR  = 3'b100,
    OR   = 3'b110,
    AND  = 3'b111
  } fn3_alu_t;

  // branch funct3
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,  // signed
    BGE  = 3'b101,  // signed
    BLTU = 3'b110,
    BGEU = 3'b111
  } fn3_bru_t;

  //////////////////////////////////////////////////
  // instruction formats, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opc_t       opc;
    logic [1:0] qdr;  // always 2'b11 for 32 bit
  } inst_r_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opc_t        opc;
    logic [1:0]  qdr;
  } inst_i_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opc_t       opc;
    logic [1:0] qdr;
  } inst_s_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opc_t       opc;
    logic [1:0] qdr;
  } inst_b_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opc_t        opc;
    logic [1:0]  qdr;
  } inst_u_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opc_t       opc;
    logic [1:0] qdr;
  } inst_j_t;

  // one fetched word, seen through every format
  typedef union packed {
    logic [31:0] raw;
    inst_r_t     r;
    inst_i_t     i;
    inst_s_t     s;
    inst_b_t     b;
    inst_u_t     u;
    inst_j_t     j;
  } inst_u;

endpackage

`default_nettype wire

/* common/mouse_ctl_pkg.sv */
/*
  control and bus region types of the mouse core
  every phase maps to exactly one bus transfer
*/
`default_nettype none

package mouse_ctl_pkg;

  // FSM phases
  typedef enum logic [2:0] {
    FETCH = 3'd0,  // instruction read
    RS1   = 3'd1,  // decode from bus, rs1 read or rd write
    RS2   = 3'd2,  // rs2 read
    EXEC  = 3'd3,  // result write or memory access
    WBACK = 3'd4   // load data to rd
  } phase_t;

  // where a transfer goes
  typedef enum logic {
    REG_GPR = 1'b0,  // internal register RAM
    REG_EXT = 1'b1   // external bus
  } region_t;

endpackage

`default_nettype wire

/* core/mouse_alu.sv */
/*
  combinational ALU for the mouse core
  compare results are only meaningful with alu_sub high
  bru_fn3 selects the branch condition from the same subtraction
*/
`timescale 1ns/1ps
`default_nettype none

module mouse_alu (
  input  logic [31:0]             alu_op1,
  input  logic [31:0]             alu_op2,
  input  mouse_isa_pkg::fn3_alu_t alu_fn3,
  input  logic                    alu_sub,
  input  mouse_isa_pkg::fn3_bru_t bru_fn3,
  output logic [31:0]             alu_res,
  output logic                    alu_brt
);

  import mouse_isa_pkg::*;

  logic [32:0] sum;  // carry out on top
  logic        eq;
  logic        lts;  // signed less than
  logic        ltu;  // unsigned less than

  // op1 + ~op2 + 1 when subtracting
  assign sum = {1'b0, alu_op1} + {1'b0, alu_op2 ^ {32{alu_sub}}} + {32'd0, alu_sub};

  assign eq  = (sum[31:0] == 32'd0);
  assign ltu = ~sum[32];  // no carry means borrow
  assign lts = (alu_op1[31] ^ alu_op2[31]) ? alu_op1[31] : sum[31];

  always_comb begin
    case (alu_fn3)
      ADD:     alu_res = sum[31:0];
      SLT:     alu_res = {31'd0, lts};
      SLTU:    alu_res = {31'd0, ltu};
      XOR:     alu_res = alu_op1 ^ alu_op2;
      OR:      alu_res = alu_op1 | alu_op2;
      AND:     alu_res = alu_op1 & alu_op2;
      default: alu_res = '0;  // shifts not built
    endcase
  end

  always_comb begin
    case (bru_fn3)
      BEQ:     alu_brt = eq;
      BNE:     alu_brt = ~eq;
      BLT:     alu_brt = lts;
      BGE:     alu_brt = ~lts;
      BLTU:    alu_brt = ltu;
      BGEU:    alu_brt = ~ltu;
      default: alu_brt = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* core/mouse_core.sv */
/*
  multi-cycle RV32I subset core with registers kept in memory
  one bus transfer per phase, read data arrives during the next transfer
  word accesses only, no shifts, no AUIPC, no SYSTEM/FENCE, no traps
  unsupported opcodes run as an idle x0 read and fall through to pc+4
  bus request must be held by the bus while bus_rdy is low
*/
`timescale 1ns/1ps
`default_nettype none

`include "mouse_params.svh"

module mouse_core (
  input  logic                    clk,
  input  logic                    rst,
  // system bus
  output logic                    bus_vld,
  output logic                    bus_wen,
  output logic [31:0]             bus_adr,
  output logic [31:0]             bus_wdt,
  input  logic [31:0]             bus_rdt,
  input  logic                    bus_rdy,
  // alu
  output logic [31:0]             alu_op1,
  output logic [31:0]             alu_op2,
  output mouse_isa_pkg::fn3_alu_t alu_fn3,
  output logic                    alu_sub,
  input  logic [31:0]             alu_res,
  input  logic                    alu_brt
);

  import mouse_isa_pkg::*;
  import mouse_ctl_pkg::*;

  localparam logic [31:0] GPR_ADR = `MOUSE_GPR_ADR;

  logic        bus_trn;    // completed transfer
  phase_t      phase;
  phase_t      phase_nxt;
  logic [31:0] pc;         // address of current instruction
  inst_u       inst_buf;
  inst_u       ins;        // decode view
  logic [31:0] dat_buf;    // rs1 or next fetch address
  logic [31:0] dat_nxt;
  logic        dat_wen;
  logic [31:0] add_op1;    // address adder
  logic [31:0] add_op2;
  logic [31:0] add_sum;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  // register index to window address
  function automatic logic [31:0] gpr_adr(input logic [4:0] idx);
    return {GPR_ADR[31:`MOUSE_GPR_AW], idx, 2'b00};
  endfunction

  assign bus_trn = bus_vld & bus_rdy;

  //////////////////////////////////////////////////
  // decode

  // instruction word is on the bus only during RS1
  assign ins.raw = (phase == RS1) ? bus_rdt : inst_buf.raw;

  assign imm_i = {{20{ins.i.imm_11_0[11]}}, ins.i.imm_11_0};
  assign imm_s = {{20{ins.s.imm_11_5[6]}}, ins.s.imm_11_5, ins.s.imm_4_0};
  assign imm_b = {{19{ins.b.imm_12}}, ins.b.imm_12, ins.b.imm_11,
                  ins.b.imm_10_5, ins.b.imm_4_1, 1'b0};
  assign imm_u = {ins.u.imm_31_12, 12'd0};
  assign imm_j = {{11{ins.j.imm_20}}, ins.j.imm_20, ins.j.imm_19_12,
                  ins.j.imm_11, ins.j.imm_10_1, 1'b0};

  assign add_sum = add_op1 + add_op2;

  //////////////////////////////////////////////////
  // alu operands
  always_comb begin
    alu_op1 = pc;     // link value pc+4 by default
    alu_op2 = 32'd4;
    alu_fn3 = ADD;
    alu_sub = 1'b0;
    if (phase == EXEC) begin
      case (ins.r.opc)
        OP_IMM: begin
          alu_op1 = bus_rdt;  // rs1
          alu_op2 = imm_i;
          alu_fn3 = fn3_alu_t'(ins.i.funct3);
          alu_sub = (alu_fn3 == SLT) || (alu_fn3 == SLTU);
        end
        OP: begin
          alu_op1 = dat_buf;  // rs1 from buffer
          alu_op2 = bus_rdt;  // rs2
          alu_fn3 = fn3_alu_t'(ins.r.funct3);
          alu_sub = (alu_fn3 == ADD) ? ins.r.funct7[5]
                                     : (alu_fn3 == SLT) || (alu_fn3 == SLTU);
        end
        BRANCH: begin
          alu_op1 = dat_buf;
          alu_op2 = bus_rdt;
          alu_fn3 = fn3_alu_t'(ins.b.funct3);  // read as branch code
          alu_sub = 1'b1;                      // compare
        end
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // bus request and next phase
  always_comb begin
    phase_nxt = phase;
    bus_wen   = 1'b0;
    bus_adr   = gpr_adr(5'd0);  // idle read of x0
    bus_wdt   = '0;
    add_op1   = pc;
    add_op2   = 32'd4;
    dat_nxt   = bus_rdt;
    dat_wen   = 1'b0;
    case (phase)
      FETCH: begin
        phase_nxt = RS1;
        // jumps and branches left their target in the buffer
        if (ins.r.opc inside {JAL, JALR, BRANCH}) bus_adr = dat_buf;
        else                                      bus_adr = add_sum;
      end
      RS1: begin
        case (ins.r.opc)
          LUI: begin
            phase_nxt = FETCH;
            bus_wen   = 1'b1;
            bus_adr   = gpr_adr(ins.u.rd);
            bus_wdt   = imm_u;
          end
          JAL: begin
            phase_nxt = FETCH;
            bus_wen   = 1'b1;
            bus_adr   = gpr_adr(ins.j.rd);
            bus_wdt   = alu_res;  // pc+4
            add_op2   = imm_j;
            dat_nxt   = add_sum;  // jump target
            dat_wen   = 1'b1;
          end
          OP_IMM, JALR, LOAD: begin
            phase_nxt = EXEC;
            bus_adr   = gpr_adr(ins.r.rs1);
          end
          OP, STORE, BRANCH: begin
            phase_nxt = RS2;
            bus_adr   = gpr_adr(ins.r.rs1);
          end
          default: phase_nxt = FETCH;  // treated as nop
        endcase
      end
      RS2: begin
        phase_nxt = EXEC;
        bus_adr   = gpr_adr(ins.r.rs2);
        dat_wen   = 1'b1;  // keep rs1 arriving now
      end
      EXEC: begin
        phase_nxt = FETCH;
        case (ins.r.opc)
          OP_IMM, OP: begin
            bus_wen = 1'b1;
            bus_adr = gpr_adr(ins.r.rd);
            bus_wdt = alu_res;
          end
          JALR: begin
            bus_wen = 1'b1;
            bus_adr = gpr_adr(ins.i.rd);
            bus_wdt = alu_res;  // pc+4
            add_op1 = bus_rdt;
            add_op2 = imm_i;
            dat_nxt = {add_sum[31:1], 1'b0};
            dat_wen = 1'b1;
          end
          LOAD: begin
            phase_nxt = WBACK;
            add_op1   = bus_rdt;
            add_op2   = imm_i;
            bus_adr   = add_sum;
          end
          STORE: begin
            bus_wen = 1'b1;
            add_op1 = dat_buf;
            add_op2 = imm_s;
            bus_adr = add_sum;
            bus_wdt = bus_rdt;  // rs2
          end
          BRANCH: begin
            // x0 read keeps the phase busy
            add_op2 = alu_brt ? imm_b : 32'd4;
            dat_nxt = add_sum;
            dat_wen = 1'b1;
          end
          default: ;
        endcase
      end
      WBACK: begin
        phase_nxt = FETCH;
        bus_wen   = 1'b1;
        bus_adr   = gpr_adr(ins.i.rd);
        bus_wdt   = bus_rdt;  // load data
      end
      default: phase_nxt = FETCH;
    endcase
  end

  //////////////////////////////////////////////////
  // state
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bus_vld      <= 1'b0;
      phase        <= FETCH;
      pc           <= `MOUSE_RST_ADR;
      inst_buf.raw <= {25'd0, JAL, 2'b11};  // JAL x0,0 sends first fetch to dat_buf
      dat_buf      <= `MOUSE_RST_ADR;
    end else begin
      bus_vld <= 1'b1;
      if (bus_trn) begin
        phase <= phase_nxt;
        if (phase == FETCH) pc <= bus_adr;
        if (phase == RS1) inst_buf.raw <= bus_rdt;
        if (dat_wen) dat_buf <= dat_nxt;
      end
    end
  end

  // fetches are reads
  assert property (@(posedge clk) disable iff (rst) (phase == FETCH) |-> !bus_wen);

  // stalled request holds until accepted
  assert property (@(posedge clk) disable iff (rst)
    bus_vld && !bus_rdy |=> bus_vld && $stable(bus_wen) && $stable(bus_adr)
                            && $stable(bus_wdt));

endmodule

`default_nettype wire

/* logic/mouse_bus_split.sv */
/*
  splits the core bus into register window and external bus
  register window is always ready, external bus follows ext_rdy
  read data is picked by the region of the previous completed transfer
*/
`timescale 1ns/1ps
`default_nettype none

`include "mouse_params.svh"

module mouse_bus_split (
  input  logic        clk,
  input  logic        rst,
  // core side
  input  logic        bus_vld,
  input  logic        bus_wen,
  input  logic [31:0] bus_adr,
  input  logic [31:0] bus_wdt,
  output logic [31:0] bus_rdt,
  output logic        bus_rdy,
  // register RAM
  output logic        gpr_vld,
  output logic        gpr_wen,
  output logic [4:0]  gpr_idx,
  output logic [31:0] gpr_wdt,
  input  logic [31:0] gpr_rdt,
  // external bus
  output logic        ext_vld,
  output logic        ext_wen,
  output logic [31:0] ext_adr,
  output logic [31:0] ext_wdt,
  input  logic [31:0] ext_rdt,
  input  logic        ext_rdy
);

  import mouse_ctl_pkg::*;

  localparam logic [31:0] GPR_ADR = `MOUSE_GPR_ADR;

  region_t reg_cur;  // region of current request
  region_t reg_dat;  // region of last completed transfer

  assign reg_cur = (bus_adr[31:`MOUSE_GPR_AW] == GPR_ADR[31:`MOUSE_GPR_AW]) ? REG_GPR
                                                                            : REG_EXT;

  // register window branch
  assign gpr_vld = bus_vld & (reg_cur == REG_GPR);
  assign gpr_wen = bus_wen & (reg_cur == REG_GPR);
  assign gpr_idx = bus_adr[`MOUSE_GPR_AW-1:2];
  assign gpr_wdt = bus_wdt;

  // external branch
  assign ext_vld = bus_vld & (reg_cur == REG_EXT);
  assign ext_wen = bus_wen & (reg_cur == REG_EXT);
  assign ext_adr = bus_adr;
  assign ext_wdt = bus_wdt;

  assign bus_rdy = (reg_cur == REG_GPR) ? 1'b1 : ext_rdy;

  // data phase follows the accepted request
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      reg_dat <= REG_EXT;
    end else if (bus_vld && bus_rdy) begin
      reg_dat <= reg_cur;
    end
  end

  assign bus_rdt = (reg_dat == REG_GPR) ? gpr_rdt : ext_rdt;

  assert property (@(posedge clk) disable iff (rst) !(gpr_vld && ext_vld));

endmodule

`default_nettype wire

/* logic/mouse_gpr_ram.sv */
/*
  register store for x1..x31, x0 reads as zero
  always ready, one access per cycle
  read data shows up after the read and stays until the next read
*/
`timescale 1ns/1ps
`default_nettype none

module mouse_gpr_ram (
  input  logic        clk,
  input  logic        rst,
  input  logic        gpr_vld,
  input  logic        gpr_wen,
  input  logic [4:0]  gpr_idx,
  input  logic [31:0] gpr_wdt,
  output logic [31:0] gpr_rdt
);

  logic [31:0] mem [1:31];  // no storage for x0
  logic        rd_x0;

  assign rd_x0 = (gpr_idx == 5'd0);

  // writes to x0 are dropped
  always_ff @(posedge clk) begin
    if (gpr_vld && gpr_wen && !rd_x0) begin
      mem[gpr_idx] <= gpr_wdt;
    end
  end

  // read port
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      gpr_rdt <= '0;
    end else if (gpr_vld && !gpr_wen) begin
      gpr_rdt <= rd_x0 ? 32'd0 : mem[gpr_idx];
    end
  end

  // x0 reads back as zero in the data phase
  assert property (@(posedge clk) disable iff (rst)
    gpr_vld && !gpr_wen && rd_x0 |=> gpr_rdt == 32'd0);

endmodule

`default_nettype wire

/* logic/mouse_top.sv */
/*
  mouse core top level
  core bus is split between the internal register RAM and the external bus
  external bus uses valid/ready with read data in the next transfer
*/
`timescale 1ns/1ps
`default_nettype none

module mouse_top (
  input  logic        clk,
  input  logic        rst,
  output logic        ext_vld,
  output logic        ext_wen,
  output logic [31:0] ext_adr,
  output logic [31:0] ext_wdt,
  input  logic [31:0] ext_rdt,
  input  logic        ext_rdy
);

  import mouse_isa_pkg::*;

  // core bus
  logic        bus_vld;
  logic        bus_wen;
  logic [31:0] bus_adr;
  logic [31:0] bus_wdt;
  logic [31:0] bus_rdt;
  logic        bus_rdy;
  // alu
  logic [31:0] alu_op1;
  logic [31:0] alu_op2;
  fn3_alu_t    alu_fn3;
  fn3_bru_t    bru_fn3;
  logic        alu_sub;
  logic [31:0] alu_res;
  logic        alu_brt;
  // register RAM
  logic        gpr_vld;
  logic        gpr_wen;
  logic [4:0]  gpr_idx;
  logic [31:0] gpr_wdt;
  logic [31:0] gpr_rdt;

  // branch code rides on the same funct3 lines
  assign bru_fn3 = fn3_bru_t'(alu_fn3);

  mouse_core core_i (
    .clk, .rst,
    .bus_vld, .bus_wen, .bus_adr, .bus_wdt, .bus_rdt, .bus_rdy,
    .alu_op1, .alu_op2, .alu_fn3, .alu_sub, .alu_res, .alu_brt
  );

  mouse_alu alu_i (
    .alu_op1, .alu_op2, .alu_fn3, .alu_sub, .bru_fn3, .alu_res, .alu_brt
  );

  mouse_bus_split split_i (
    .clk, .rst,
    .bus_vld, .bus_wen, .bus_adr, .bus_wdt, .bus_rdt, .bus_rdy,
    .gpr_vld, .gpr_wen, .gpr_idx, .gpr_wdt, .gpr_rdt,
    .ext_vld, .ext_wen, .ext_adr, .ext_wdt, .ext_rdt, .ext_rdy
  );

  mouse_gpr_ram gpr_i (
    .clk, .rst, .gpr_vld, .gpr_wen, .gpr_idx, .gpr_wdt, .gpr_rdt
  );

endmodule

`default_nettype wire

/* bench/mouse_tb.sv */
/*
  testbench for the mouse core top level
  external memory is 1024 words at address 0 with the program from word 0 and data at 0x400
  read data follows the pipelined rule
  ext_rdy is random from an LCG
  an instruction-set reference predicts every external transfer
  run ends once the final JAL x0,0 loop has been fetched three times
*/
`timescale 1ns/1ps
`default_nettype none

`include "mouse_params.svh"

module mouse_tb;

  localparam int MEM_WORDS = 1024;
  localparam int IDLE_MAX  = 200;    // cycles without a completed external transfer
  localparam int RUN_MAX   = 20000;  // cycles for the whole program

  logic        clk;
  logic        rst;
  logic        ext_vld;
  logic        ext_wen;
  logic [31:0] ext_adr;
  logic [31:0] ext_wdt;
  logic [31:0] ext_rdt;
  logic        ext_rdy;

  logic [31:0] mem [0:MEM_WORDS-1];      // DUT side memory
  logic [31:0] ref_mem [0:MEM_WORDS-1];  // reference memory
  logic [31:0] ref_x [0:31];
  logic [31:0] ref_pc;
  int          loops;                    // fetches of the final loop
  logic [31:0] rng;
  logic [31:0] exp_adr [$];              // predicted transfers
  logic        exp_wen [$];
  logic [31:0] exp_wdt [$];
  int          prog_w;                   // next program word
  int          st_off;                   // next store slot
  // transfer handed from the monitor to the memory model
  logic        pend;
  logic        pend_wen;
  logic [31:0] pend_adr;
  logic [31:0] pend_wdt;
  // stall tracking
  logic        hold;
  logic        hold_wen;
  logic [31:0] hold_adr;
  logic [31:0] hold_wdt;
  logic        rst_q;
  int          idle;
  int          n;

  mouse_top mouse_top_i (
    .clk, .rst,
    .ext_vld, .ext_wen, .ext_adr, .ext_wdt, .ext_rdt, .ext_rdy
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  //////////////////////////////////////////////////
  // instruction encoders
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};  // SW
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic put(input logic [31:0] w);
    mem[prog_w] = w;
    prog_w++;
  endtask

  // LUI + ADDI with the upper part rounded for the signed low part
  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800;
    put({hi[31:12], rd, 7'h37});
    put(enc_i(v[11:0], rd, 3'd0, rd, 7'h13));
  endtask

  task automatic store_reg(input logic [4:0] rs);
    put(enc_s(st_off[11:0], rs, 5'd10));
    st_off += 4;
  endtask

  task automatic build_prog();
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  br_f3 [6];
    logic [2:0]  op_f3 [6];
    br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    op_f3 = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
    rng = lcg_next(rng);
    a = rng | 32'h8000_0000;  // negative so signed and unsigned compares differ
    rng = lcg_next(rng);
    b = rng & 32'h7fff_ffff;
    load_const(5'd1, a);
    load_const(5'd2, b);
    load_const(5'd10, 32'h400);  // data base
    put(enc_i(12'd0, 5'd0, 3'd0, 5'd7, 7'h13));  // x7 counts skipped paths
    // OP including SUB
    put(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd5));
    store_reg(5'd5);
    foreach (op_f3[k]) begin
      put(enc_r(7'h00, 5'd2, 5'd1, op_f3[k], 5'd5));
      store_reg(5'd5);
    end
    // OP-IMM with random immediates
    foreach (op_f3[k]) begin
      rng = lcg_next(rng);
      put(enc_i(rng[27:16], 5'd1, op_f3[k], 5'd5, 7'h13));
      store_reg(5'd5);
    end
    // load back the first stored word
    put(enc_i(12'd0, 5'd10, 3'b010, 5'd6, 7'h03));
    store_reg(5'd6);
    // x0 stays zero
    put(enc_i(12'd5, 5'd1, 3'd0, 5'd0, 7'h13));
    store_reg(5'd0);
    // each branch skips one increment when taken
    foreach (br_f3[k]) begin
      put(enc_b(13'd8, 5'd2, 5'd1, br_f3[k]));
      put(enc_i(12'd1, 5'd7, 3'd0, 5'd7, 7'h13));
      put(enc_b(13'd8, 5'd1, 5'd2, br_f3[k]));
      put(enc_i(12'd1, 5'd7, 3'd0, 5'd7, 7'h13));
      put(enc_b(13'd8, 5'd1, 5'd1, br_f3[k]));
      put(enc_i(12'd1, 5'd7, 3'd0, 5'd7, 7'h13));
    end
    // JAL then JALR off the link
    put(enc_j(21'd8, 5'd8));
    put(enc_i(12'd1, 5'd7, 3'd0, 5'd7, 7'h13));
    put(enc_i(12'd12, 5'd8, 3'd0, 5'd11, 7'h67));
    put(enc_i(12'd1, 5'd7, 3'd0, 5'd7, 7'h13));
    store_reg(5'd8);
    store_reg(5'd11);
    store_reg(5'd7);
    put(enc_j(21'd0, 5'd0));  // final loop
  endtask

  //////////////////////////////////////////////////
  // reference model
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return sub ? a - b : a + b;
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd6:    return a | b;
      3'd7:    return a & b;
      default: return 32'd0;
    endcase
  endfunction

  function automatic logic br_taken(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      3'd7:    return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic void push_exp(input logic [31:0] adr, input logic wen,
                                   input logic [31:0] wdt);
    exp_adr.push_back(adr);
    exp_wen.push_back(wen);
    exp_wdt.push_back(wdt);
  endfunction

  // one instruction and its predicted external transfers
  function automatic void ref_step();
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] nxt;
    logic [31:0] ea;
    logic [31:0] res;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        wr;
    ins   = ref_mem[ref_pc[11:2]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    a     = ref_x[ins[19:15]];
    b     = ref_x[ins[24:20]];
    nxt   = ref_pc + 32'd4;
    res   = 32'd0;
    wr    = 1'b0;
    push_exp(ref_pc, 1'b0, 32'd0);  // fetch
    case (ins[6:0])
      7'h37: begin
        res = {ins[31:12], 12'd0};
        wr  = 1'b1;
      end
      7'h6f: begin
        res = nxt;
        wr  = 1'b1;
        if (ins == 32'h0000_006f) loops++;
        nxt = ref_pc + imm_j;
      end
      7'h67: begin
        res = nxt;
        wr  = 1'b1;
        nxt = (a + imm_i) & ~32'd1;
      end
      7'h63: if (br_taken(ins[14:12], a, b)) nxt = ref_pc + imm_b;
      7'h03: begin
        ea  = a + imm_i;
        push_exp(ea, 1'b0, 32'd0);
        res = ref_mem[ea[11:2]];
        wr  = 1'b1;
      end
      7'h23: begin
        ea = a + imm_s;
        push_exp(ea, 1'b1, b);
        ref_mem[ea[11:2]] = b;
      end
      7'h13: begin
        res = alu_ref(ins[14:12], 1'b0, a, imm_i);
        wr  = 1'b1;
      end
      7'h33: begin
        res = alu_ref(ins[14:12], ins[30], a, b);
        wr  = 1'b1;
      end
      default: ;
    endcase
    if (wr && ins[11:7] != 5'd0) ref_x[ins[11:7]] = res;
    ref_pc = nxt;
  endfunction

  task automatic fail_stop();
    $display("RESULT: FAIL");
    $fatal(1, "check failed");
  endtask

  //////////////////////////////////////////////////
  // comparison process samples at the rising edge
  always @(posedge clk) begin
    if (rst || rst_q) begin
      assert (!ext_vld) else begin
        $display("ext_vld was high during reset or in the cycle after it");
        fail_stop();
      end
    end
    rst_q = rst;
    if (!rst) begin
      if (hold) begin
        assert (ext_vld) else begin
          $display("[FAIL] ext_vld dropped while stalled: got %h exp %h", ext_vld, 1'b1);
          fail_stop();
        end
        assert (ext_adr == hold_adr && ext_wen == hold_wen && ext_wdt == hold_wdt) else begin
          $display("[FAIL] ext_adr/ext_wen/ext_wdt changed in stall: got %h/%h/%h exp %h/%h/%h",
                   ext_adr, ext_wen, ext_wdt, hold_adr, hold_wen, hold_wdt);
          fail_stop();
        end
      end
      hold     = ext_vld && !ext_rdy;
      hold_adr = ext_adr;
      hold_wen = ext_wen;
      hold_wdt = ext_wdt;
      if (ext_vld && ext_rdy) begin
        idle = 0;
        if (exp_adr.size() == 0) ref_step();
        assert (ext_adr == exp_adr[0]) else begin
          $display("[FAIL] ext_adr got %h exp %h", ext_adr, exp_adr[0]);
          fail_stop();
        end
        assert (ext_wen == exp_wen[0]) else begin
          $display("[FAIL] ext_wen got %h exp %h (ext_adr %h)", ext_wen, exp_wen[0], ext_adr);
          fail_stop();
        end
        if (exp_wen[0]) begin
          assert (ext_wdt == exp_wdt[0]) else begin
            $display("[FAIL] ext_wdt got %h exp %h (ext_adr %h)", ext_wdt, exp_wdt[0], ext_adr);
            fail_stop();
          end
        end
        void'(exp_adr.pop_front());
        void'(exp_wen.pop_front());
        void'(exp_wdt.pop_front());
        pend     = 1'b1;
        pend_wen = ext_wen;
        pend_adr = ext_adr;
        pend_wdt = ext_wdt;
      end else begin
        idle++;
        assert (idle < IDLE_MAX) else begin
          $display("no external transfer completed for %0d cycles", IDLE_MAX);
          fail_stop();
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // memory model drives on the falling edge
  always @(negedge clk) begin
    if (pend) begin
      if (pend_wen) mem[pend_adr[11:2]] = pend_wdt;
      else          ext_rdt <= mem[pend_adr[11:2]];  // data for the next transfer
      pend = 1'b0;
    end
    if (!rst) begin
      rng = lcg_next(rng);
      ext_rdy <= (rng[17:16] != 2'b00);  // ready about 3 of 4 cycles
    end
  end

  initial begin
    rst     = 1'b1;
    ext_rdy = 1'b0;
    ext_rdt = 32'd0;
    rng     = 32'd35364;
    pend    = 1'b0;
    hold    = 1'b0;
    rst_q   = 1'b1;
    idle    = 0;
    loops   = 0;
    prog_w  = `MOUSE_RST_ADR >> 2;
    st_off  = 0;
    // fill depends on the full word address
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = (i * 32'h9e37_79b9) ^ {i[15:0], ~i[15:0]};
    build_prog();
    for (int i = 0; i < MEM_WORDS; i++) ref_mem[i] = mem[i];
    for (int i = 0; i < 32; i++) ref_x[i] = 32'd0;
    ref_pc = `MOUSE_RST_ADR;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst <= 1'b0;
    for (n = 0; n < RUN_MAX && !(loops >= 3 && exp_adr.size() == 0); n++) @(negedge clk);
    if (loops >= 3 && exp_adr.size() == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("program did not reach its final loop within %0d cycles", RUN_MAX);
      fail_stop();
    end
  end

endmodule

`default_nettype wire

/* mouse.f */
+incdir+common
common/mouse_isa_pkg.sv
common/mouse_ctl_pkg.sv
core/mouse_alu.sv
core/mouse_core.sv
logic/mouse_bus_split.sv
logic/mouse_gpr_ram.sv
logic/mouse_top.sv
bench/mouse_tb.sv

/* Bender.yml */
package:
  name: mouse

sources:
  - include_dirs:
      - common
    files:
      - common/mouse_isa_pkg.sv
      - common/mouse_ctl_pkg.sv
      - core/mouse_alu.sv
      - core/mouse_core.sv
      - logic/mouse_bus_split.sv
      - logic/mouse_gpr_ram.sv
      - logic/mouse_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/mouse_tb.sv
